/* design/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// width of one stored word
`define MEM_WORD_W 18

// word offset inside one bank, 1024 words per bank
`define MEM_OFFSET_W 10

// bank number taken from the upper address bits
`define MEM_BANK_W 5

// only banks 0 to 29 are populated, so 30 and 31 raise a fault
`define MEM_NUM_BANKS 30

// full port address, bank index above offset
`define MEM_ADDR_W (`MEM_BANK_W + `MEM_OFFSET_W)

`endif

/* design/mem_pkg.sv */
`include "mem_macros.svh"

package mem_pkg;

	// one data word
	typedef logic [`MEM_WORD_W-1:0] word_t;

	// word offset within a bank
	typedef logic [`MEM_OFFSET_W-1:0] offset_t;

	// bank number
	typedef logic [`MEM_BANK_W-1:0] bank_idx_t;

	// bank index in the upper bits, offset in the lower bits
	typedef logic [`MEM_ADDR_W-1:0] addr_t;

	// one bit per populated bank
	typedef logic [`MEM_NUM_BANKS-1:0] bank_vec_t;

	// access type for one port in one cycle
	typedef enum logic [1:0] {
		op_idle  = 2'b00,
		op_read  = 2'b01,
		op_write = 2'b10
	} mem_op_t;

endpackage

/* design/mem_port_if.sv */
`timescale 1ns/1ps

`include "mem_macros.svh"

// one port's requests to the bank array and the read data of every bank
interface mem_port_if;
	import mem_pkg::*;

	// at most one bit is set in a cycle
	bank_vec_t bank_en;

	// write strobe, applies to the enabled bank only
	logic bank_we;

	offset_t offset;
	word_t wdata;

	// registered read data of each bank as seen by this port
	word_t bank_rdata [`MEM_NUM_BANKS];

	modport ctrl (
		output bank_en,
		output bank_we,
		output offset,
		output wdata,
		input  bank_rdata
	);

	modport bank (
		input  bank_en,
		input  bank_we,
		input  offset,
		input  wdata,
		output bank_rdata
	);

endinterface

/* design/port_controller.sv */
`timescale 1ns/1ps

`include "mem_macros.svh"

module port_controller (
	input  logic              CLK,
	input  logic              reset,
	input  mem_pkg::mem_op_t  op,
	input  mem_pkg::addr_t    addr,
	input  mem_pkg::word_t    wdata,
	output mem_pkg::word_t    rdata,
	output logic              valid,
	output logic              fault,
	mem_port_if.ctrl          bus
);
	import mem_pkg::*;

	bank_idx_t bank_idx;
	offset_t offset;

	logic is_read;
	logic is_write;
	logic active;
	logic bank_ok;

	// bank of the access whose result is on the outputs this cycle
	bank_idx_t sel_q;

	assign bank_idx = addr[`MEM_ADDR_W-1:`MEM_OFFSET_W];
	assign offset = addr[`MEM_OFFSET_W-1:0];

	assign is_read = (op == op_read);
	assign is_write = (op == op_write);
	assign active = is_read || is_write;

	// banks 30 and 31 are not built
	assign bank_ok = (bank_idx < bank_idx_t'(`MEM_NUM_BANKS));

	// one-hot bank enable, nothing is enabled for idle or a missing bank
	always_comb begin
		bus.bank_en = '0;
		if (active && bank_ok) begin
			bus.bank_en[bank_idx] = 1'b1;
		end
	end

	assign bus.bank_we = is_write;
	assign bus.offset = offset;
	assign bus.wdata = wdata;

	// the bank select is captured at the same edge as the bank access
	// so the read-back mux follows the access and not the next address
	always_ff @(posedge CLK) begin
		if (reset) begin
			valid <= 1'b0;
			fault <= 1'b0;
			sel_q <= '0;
		end else begin
			valid <= active;
			fault <= active && !bank_ok;
			if (active && bank_ok) begin
				sel_q <= bank_idx;
			end
		end
	end

	// zero on a fault and outside a result cycle
	always_comb begin
		if (valid && !fault) begin
			rdata = bus.bank_rdata[sel_q];
		end else begin
			rdata = '0;
		end
	end

endmodule

/* design/bank_array.sv */
`timescale 1ns/1ps

`include "mem_macros.svh"

module bank_array (
	input  logic      CLK,
	mem_port_if.bank  port_a,
	mem_port_if.bank  port_b
);
	import mem_pkg::*;

	localparam int DEPTH = 1 << `MEM_OFFSET_W;

	genvar i;

	generate
		for (i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
			word_t mem [DEPTH];
			word_t rd_a;
			word_t rd_b;

			// both ports may write, never to the same word in one cycle
			always_ff @(posedge CLK) begin
				if (port_a.bank_en[i] && port_a.bank_we) begin
					mem[port_a.offset] <= port_a.wdata;
				end
				if (port_b.bank_en[i] && port_b.bank_we) begin
					mem[port_b.offset] <= port_b.wdata;
				end
			end

			// a write returns its own data, a read returns the word before any
			// write from the other port at the same edge
			always_ff @(posedge CLK) begin
				if (port_a.bank_en[i]) begin
					if (port_a.bank_we) begin
						rd_a <= port_a.wdata;
					end else begin
						rd_a <= mem[port_a.offset];
					end
				end
			end

			always_ff @(posedge CLK) begin
				if (port_b.bank_en[i]) begin
					if (port_b.bank_we) begin
						rd_b <= port_b.wdata;
					end else begin
						rd_b <= mem[port_b.offset];
					end
				end
			end

			assign port_a.bank_rdata[i] = rd_a;
			assign port_b.bank_rdata[i] = rd_b;
		end
	endgenerate

endmodule

/* design/banked_memory.sv */
`timescale 1ns/1ps

module banked_memory (
	input  logic              CLK,
	input  logic              reset,

	input  mem_pkg::mem_op_t  a_op,
	input  mem_pkg::addr_t    a_addr,
	input  mem_pkg::word_t    a_wdata,
	output mem_pkg::word_t    a_rdata,
	output logic              a_valid,
	output logic              a_fault,

	input  mem_pkg::mem_op_t  b_op,
	input  mem_pkg::addr_t    b_addr,
	input  mem_pkg::word_t    b_wdata,
	output mem_pkg::word_t    b_rdata,
	output logic              b_valid,
	output logic              b_fault
);

	// one request bus per port
	mem_port_if port_a_bus ();
	mem_port_if port_b_bus ();

	port_controller port_a_ctrl (
		.CLK    (CLK),
		.reset  (reset),
		.op     (a_op),
		.addr   (a_addr),
		.wdata  (a_wdata),
		.rdata  (a_rdata),
		.valid  (a_valid),
		.fault  (a_fault),
		.bus    (port_a_bus.ctrl)
	);

	port_controller port_b_ctrl (
		.CLK    (CLK),
		.reset  (reset),
		.op     (b_op),
		.addr   (b_addr),
		.wdata  (b_wdata),
		.rdata  (b_rdata),
		.valid  (b_valid),
		.fault  (b_fault),
		.bus    (port_b_bus.ctrl)
	);

	// every bank serves both ports at once
	bank_array bank_array_i (
		.CLK     (CLK),
		.port_a  (port_a_bus.bank),
		.port_b  (port_b_bus.bank)
	);

endmodule

/* verif/banked_memory_assertions.sv */
`timescale 1ns/1ps

module banked_memory_assertions (
	input logic              CLK,
	input logic              reset,
	input mem_pkg::mem_op_t  a_op,
	input mem_pkg::addr_t    a_addr,
	input mem_pkg::word_t    a_rdata,
	input logic              a_valid,
	input logic              a_fault,
	input mem_pkg::mem_op_t  b_op,
	input mem_pkg::addr_t    b_addr,
	input mem_pkg::word_t    b_rdata,
	input logic              b_valid,
	input logic              b_fault
);
	import mem_pkg::*;

	// a result cycle needs an access at the edge before it, and none comes out of reset
	a_valid_needs_op: assert property (@(posedge CLK) disable iff (reset)
		a_valid |-> ($past(a_op) != op_idle && !$past(reset)))
		else $error("a_valid high without an access in the previous cycle");

	b_valid_needs_op: assert property (@(posedge CLK) disable iff (reset)
		b_valid |-> ($past(b_op) != op_idle && !$past(reset)))
		else $error("b_valid high without an access in the previous cycle");

	a_fault_needs_valid: assert property (@(posedge CLK) disable iff (reset)
		a_fault |-> a_valid)
		else $error("a_fault high while a_valid is low");

	b_fault_needs_valid: assert property (@(posedge CLK) disable iff (reset)
		b_fault |-> b_valid)
		else $error("b_fault high while b_valid is low");

	a_fault_zero_data: assert property (@(posedge CLK) disable iff (reset)
		a_fault |-> (a_rdata == '0))
		else $error("a_rdata not zero on a fault");

	b_fault_zero_data: assert property (@(posedge CLK) disable iff (reset)
		b_fault |-> (b_rdata == '0))
		else $error("b_rdata not zero on a fault");

	// both ports writing one word in the same cycle has no defined result
	no_double_write: assert property (@(posedge CLK) disable iff (reset)
		!(a_op == op_write && b_op == op_write && a_addr == b_addr))
		else $error("both ports write the same word in one cycle");

endmodule

/* verif/banked_memory_tb.sv */
`timescale 1ns/1ps

`include "mem_macros.svh"

module banked_memory_tb;
	import mem_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 2000;
	localparam int unsigned SEED = 32'h1038;
	localparam int BANK_DEPTH = 1 << `MEM_OFFSET_W;
	localparam string PATTERN_FILE = "verif/mem_patterns.txt";

	// one line of the pattern file
	typedef struct {
		mem_op_t a_op;
		addr_t   a_addr;
		word_t   a_wdata;
		mem_op_t b_op;
		addr_t   b_addr;
		word_t   b_wdata;
		word_t   exp_a_rdata;
		logic    exp_a_fault;
		word_t   exp_b_rdata;
		logic    exp_b_fault;
	} pattern_t;

	logic CLK;
	logic reset;

	mem_op_t a_op;
	addr_t a_addr;
	word_t a_wdata;
	word_t a_rdata;
	logic a_valid;
	logic a_fault;

	mem_op_t b_op;
	addr_t b_addr;
	word_t b_wdata;
	word_t b_rdata;
	logic b_valid;
	logic b_fault;

	pattern_t patterns [$];
	bit patterns_loaded = 1'b0;

	// reference contents of the populated banks
	word_t model [`MEM_NUM_BANKS][BANK_DEPTH];

	// addresses that hold a known word
	addr_t known_q [$];

	banked_memory banked_memory_i (
		.CLK      (CLK),
		.reset    (reset),
		.a_op     (a_op),
		.a_addr   (a_addr),
		.a_wdata  (a_wdata),
		.a_rdata  (a_rdata),
		.a_valid  (a_valid),
		.a_fault  (a_fault),
		.b_op     (b_op),
		.b_addr   (b_addr),
		.b_wdata  (b_wdata),
		.b_rdata  (b_rdata),
		.b_valid  (b_valid),
		.b_fault  (b_fault)
	);

	bind banked_memory banked_memory_assertions banked_memory_assertions_i (
		.CLK      (CLK),
		.reset    (reset),
		.a_op     (a_op),
		.a_addr   (a_addr),
		.a_rdata  (a_rdata),
		.a_valid  (a_valid),
		.a_fault  (a_fault),
		.b_op     (b_op),
		.b_addr   (b_addr),
		.b_rdata  (b_rdata),
		.b_valid  (b_valid),
		.b_fault  (b_fault)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, expected));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, expected));
		end
	endtask

	task automatic load_patterns();
		int fd;
		int fields;
		int line_no;
		string line;
		logic [31:0] f [10];
		pattern_t p;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			abort_run({"cannot open the pattern file ", PATTERN_FILE});
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			line_no++;
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
				continue;
			end
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
			if (fields != 10) begin
				abort_run($sformatf("pattern line %0d does not hold ten fields", line_no));
			end
			if (f[0] > 2 || f[3] > 2) begin
				abort_run($sformatf("pattern line %0d holds an unknown opcode", line_no));
			end
			p.a_op = mem_op_t'(f[0][1:0]);
			p.a_addr = f[1][`MEM_ADDR_W-1:0];
			p.a_wdata = f[2][`MEM_WORD_W-1:0];
			p.b_op = mem_op_t'(f[3][1:0]);
			p.b_addr = f[4][`MEM_ADDR_W-1:0];
			p.b_wdata = f[5][`MEM_WORD_W-1:0];
			p.exp_a_rdata = f[6][`MEM_WORD_W-1:0];
			p.exp_a_fault = f[7][0];
			p.exp_b_rdata = f[8][`MEM_WORD_W-1:0];
			p.exp_b_fault = f[9][0];
			patterns.push_back(p);
		end
		$fclose(fd);
	endtask

	// expected result of one port access, taken before this cycle's writes land
	task automatic predict(input mem_op_t op, input addr_t addr, input word_t wdata,
			output word_t exp_data, output logic exp_fault);
		bank_idx_t bank;
		offset_t offset;
		bank = addr[`MEM_ADDR_W-1:`MEM_OFFSET_W];
		offset = addr[`MEM_OFFSET_W-1:0];
		exp_data = '0;
		exp_fault = 1'b0;
		if (op != op_idle) begin
			if (bank >= `MEM_NUM_BANKS) begin
				exp_fault = 1'b1;
			end else if (op == op_write) begin
				exp_data = wdata;
			end else begin
				exp_data = model[bank][offset];
			end
		end
	endtask

	task automatic commit_write(input mem_op_t op, input addr_t addr, input word_t wdata);
		bank_idx_t bank;
		offset_t offset;
		bank = addr[`MEM_ADDR_W-1:`MEM_OFFSET_W];
		offset = addr[`MEM_OFFSET_W-1:0];
		if (op == op_write && bank < `MEM_NUM_BANKS) begin
			model[bank][offset] = wdata;
			known_q.push_back(addr);
		end
	endtask

	// drives one cycle on both ports and checks the results after the next edge
	task automatic run_access(input mem_op_t op_a, input addr_t addr_a, input word_t wd_a,
			input mem_op_t op_b, input addr_t addr_b, input word_t wd_b,
			input word_t exp_a, input logic exp_a_fault,
			input word_t exp_b, input logic exp_b_fault);
		a_op = op_a;
		a_addr = addr_a;
		a_wdata = wd_a;
		b_op = op_b;
		b_addr = addr_b;
		b_wdata = wd_b;
		@(posedge CLK);
		#1;
		check_flag("a_valid", a_valid, op_a != op_idle);
		check_flag("a_fault", a_fault, exp_a_fault);
		if (op_a != op_idle) begin
			check_word("a_rdata", a_rdata, exp_a);
		end
		check_flag("b_valid", b_valid, op_b != op_idle);
		check_flag("b_fault", b_fault, exp_b_fault);
		if (op_b != op_idle) begin
			check_word("b_rdata", b_rdata, exp_b);
		end
	endtask

	task automatic play_patterns();
		pattern_t p;
		foreach (patterns[i]) begin
			p = patterns[i];
			run_access(p.a_op, p.a_addr, p.a_wdata, p.b_op, p.b_addr, p.b_wdata,
				p.exp_a_rdata, p.exp_a_fault, p.exp_b_rdata, p.exp_b_fault);
			commit_write(p.a_op, p.a_addr, p.a_wdata);
			commit_write(p.b_op, p.b_addr, p.b_wdata);
		end
	endtask

	task automatic pick_access(output mem_op_t op, output addr_t addr, output word_t wdata);
		logic [31:0] r;
		logic [31:0] sel;
		int unsigned kind;
		int unsigned pick;
		bank_idx_t bank;
		offset_t offset;
		r = $urandom;
		wdata = r[`MEM_WORD_W-1:0];
		r = $urandom;
		bank = r[`MEM_BANK_W-1:0];
		offset = '0;
		if (r[31:30] == 2'b00) begin
			offset = r[`MEM_ADDR_W-1:`MEM_BANK_W];
		end else begin
			// most accesses share a small window so that reads meet recent writes
			offset[3:0] = r[8:5];
		end
		addr = {bank, offset};
		kind = $urandom % 8;
		if (kind < 2) begin
			op = op_idle;
		end else if (kind < 5) begin
			op = op_read;
			sel = $urandom;
			if (known_q.size() > 0 && sel[2:0] != 3'b000) begin
				pick = $urandom % known_q.size();
				addr = known_q[pick];
			end else if (bank < `MEM_NUM_BANKS) begin
				// an unwritten word has no defined value, so this read goes to a missing bank
				bank = r[9] ? bank_idx_t'(31) : bank_idx_t'(`MEM_NUM_BANKS);
				addr = {bank, offset};
			end
		end else begin
			op = op_write;
		end
	endtask

	task automatic random_traffic();
		mem_op_t op_a;
		mem_op_t op_b;
		addr_t addr_a;
		addr_t addr_b;
		word_t wd_a;
		word_t wd_b;
		word_t exp_a;
		word_t exp_b;
		logic fault_a;
		logic fault_b;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			pick_access(op_a, addr_a, wd_a);
			pick_access(op_b, addr_b, wd_b);
			if (op_a == op_write && op_b == op_write && addr_a == addr_b) begin
				op_b = op_idle;
			end
			predict(op_a, addr_a, wd_a, exp_a, fault_a);
			predict(op_b, addr_b, wd_b, exp_b, fault_b);
			run_access(op_a, addr_a, wd_a, op_b, addr_b, wd_b, exp_a, fault_a, exp_b, fault_b);
			commit_write(op_a, addr_a, wd_a);
			commit_write(op_b, addr_b, wd_b);
		end
	endtask

	initial begin
		int timeout_ns;
		wait (patterns_loaded);
		timeout_ns = (patterns.size() + RANDOM_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;
		#(timeout_ns);
		abort_run($sformatf("timeout, the run did not end within %0d ns", timeout_ns));
	end

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		a_op = op_idle;
		a_addr = '0;
		a_wdata = '0;
		b_op = op_idle;
		b_addr = '0;
		b_wdata = '0;
		void'($urandom(SEED));
		load_patterns();
		patterns_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		reset = 1'b0;
		play_patterns();
		random_traffic();
		$display("Test passed");
		$finish;
	end

endmodule

/* verif/mem_patterns.txt */
# a_op a_addr a_wdata b_op b_addr b_wdata exp_a_rdata exp_a_fault exp_b_rdata exp_b_fault
# all fields hex, op 0 idle 1 read 2 write, expected values are the results one cycle later
0 0000 00000 0 0000 00000 00000 0 00000 0
0 0000 00000 0 0000 00000 00000 0 00000 0
2 0000 12345 0 0000 00000 12345 0 00000 0
1 0000 00000 0 0000 00000 12345 0 00000 0
0 0000 00000 0 0000 00000 00000 0 00000 0
0 0000 00000 2 77ff 3ffff 00000 0 3ffff 0
0 0000 00000 1 77ff 00000 00000 0 3ffff 0
2 0405 0abcd 2 0880 2d0f0 0abcd 0 2d0f0 0
1 0880 00000 1 0405 00000 2d0f0 0 0abcd 0
2 1d23 15555 0 0000 00000 15555 0 00000 0
0 0000 00000 1 1d23 00000 00000 0 15555 0
2 1d23 2aaaa 1 1d23 00000 2aaaa 0 15555 0
0 0000 00000 1 1d23 00000 00000 0 2aaaa 0
1 77ff 00000 2 77ff 00001 3ffff 0 00001 0
1 77ff 00000 0 0000 00000 00001 0 00000 0
2 3123 11111 2 3d23 22222 11111 0 22222 0
1 1d23 00000 1 3123 00000 2aaaa 0 11111 0
1 3d23 00000 0 0000 00000 22222 0 00000 0
2 0880 00777 1 0000 00000 00777 0 12345 0
2 0010 20010 2 3c10 23c10 20010 0 23c10 0
2 0410 20410 2 4010 24010 20410 0 24010 0
2 0810 20810 2 4410 24410 20810 0 24410 0
2 0c10 20c10 2 4810 24810 20c10 0 24810 0
2 1010 21010 2 4c10 24c10 21010 0 24c10 0
2 1410 21410 2 5010 25010 21410 0 25010 0
2 1810 21810 2 5410 25410 21810 0 25410 0
2 1c10 21c10 2 5810 25810 21c10 0 25810 0
2 2010 22010 2 5c10 25c10 22010 0 25c10 0
2 2410 22410 2 6010 26010 22410 0 26010 0
2 2810 22810 2 6410 26410 22810 0 26410 0
2 2c10 22c10 2 6810 26810 22c10 0 26810 0
2 3010 23010 2 6c10 26c10 23010 0 26c10 0
2 3410 23410 2 7010 27010 23410 0 27010 0
2 3810 23810 2 7410 27410 23810 0 27410 0
2 7810 3ffff 2 7c10 3ffff 00000 1 00000 1
1 7bff 00000 1 7c10 00000 00000 1 00000 1
1 0010 00000 1 3c10 00000 20010 0 23c10 0
1 0410 00000 1 4010 00000 20410 0 24010 0
1 0810 00000 1 4410 00000 20810 0 24410 0
1 0c10 00000 1 4810 00000 20c10 0 24810 0
1 1010 00000 1 4c10 00000 21010 0 24c10 0
1 1410 00000 1 5010 00000 21410 0 25010 0
1 1810 00000 1 5410 00000 21810 0 25410 0
1 1c10 00000 1 5810 00000 21c10 0 25810 0
1 2010 00000 1 5c10 00000 22010 0 25c10 0
1 2410 00000 1 6010 00000 22410 0 26010 0
1 2810 00000 1 6410 00000 22810 0 26410 0
1 2c10 00000 1 6810 00000 22c10 0 26810 0
1 3010 00000 1 6c10 00000 23010 0 26c10 0
1 3410 00000 1 7010 00000 23410 0 27010 0
1 3810 00000 1 7410 00000 23810 0 27410 0
0 0000 00000 0 0000 00000 00000 0 00000 0

/* compile.f */
+incdir+design
design/mem_pkg.sv
design/mem_port_if.sv
design/port_controller.sv
design/bank_array.sv
design/banked_memory.sv
verif/banked_memory_assertions.sv
verif/banked_memory_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the banked memory testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=banked_memory_sim
LOG=sim.log

verilator --binary --timing --assert \
	-f compile.f \
	--top-module banked_memory_tb \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

# the testbench prints the fail message on any mismatch or timeout
if grep -q "Test failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

# an assertion stop leaves no fail message but a bad exit status
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation finished cleanly"
exit 0
